// ==== rtl/tpu_defs.svh ====
// TPU external port
// Width and size definitions

`ifndef TPU_DEFS_SVH
`define TPU_DEFS_SVH

////////////////////////////////////////
// Word link and addressing
`define WIDTH_DATA		32
`define WIDTH_ADDR		16
`define WIDTH_STRIDE	15			// Top bit of the stride word selects load

////////////////////////////////////////
// Buffer and memory sizing
`define BUFF_SIZE		16			// Ring buffer entries
`define MEM_DEPTH		256			// Power of two, address walk wraps on it
`define GRANT_DELAY		2			// Request to grant, at least 1

`endif

// ==== rtl/tpu_pkg.sv ====
// TPU external port types

`include "tpu_defs.svh"

package tpu_pkg;

	typedef logic [`WIDTH_DATA-1:0]		data_t;
	typedef logic [`WIDTH_ADDR-1:0]		address_t;
	typedef logic [`WIDTH_STRIDE-1:0]	stride_t;

	////////////////////////////////////////
	// Link and memory port bundles

	typedef struct packed {
		logic		req;			// One cycle per word
		data_t		data;
		logic		rls;			// Last word of a load
	} ext_word_t;

	typedef struct packed {
		address_t	length;
		stride_t	stride;
		address_t	base;
	} acc_cfg_t;

	typedef struct packed {
		logic		req;
		acc_cfg_t	cfg;
	} mem_req_t;

	typedef struct packed {
		logic		valid;
		data_t		data;
		logic		term;			// High on the last load word
	} ld_rsp_t;

	typedef struct packed {
		logic		valid;
		data_t		data;
	} st_beat_t;

	////////////////////////////////////////
	// Port handler state machines

	typedef enum logic [2:0] {
		SERV_IDLE,					// Waiting for the stride word
		SERV_LENGTH,
		SERV_BASE,
		SERV_SET,					// Request cycle
		SERV_RUN
	} serv_state_t;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_WAIT,
		ST_RUN
	} st_state_t;

	typedef enum logic [1:0] {
		LD_IDLE,
		LD_WAIT,
		LD_RUN,
		LD_LAST						// Forwarding the term word
	} ld_state_t;

endpackage

// ==== rtl/ring_buff_ctrl.sv ====
// Ring buffer pointer control

`timescale 1ns/1ps
`include "tpu_defs.svh"

module ring_buff_ctrl #(
	parameter int NUM_ENTRY = `BUFF_SIZE
)(
	input  logic							clock,
	input  logic							reset,
	input  logic							we,
	input  logic							re,
	output logic [$clog2(NUM_ENTRY)-1:0]	wr_ptr,
	output logic [$clog2(NUM_ENTRY)-1:0]	rd_ptr,
	output logic							full,
	output logic							empty,
	output logic [$clog2(NUM_ENTRY):0]		num
);

	localparam int WIDTH_PTR = $clog2(NUM_ENTRY);

	logic	do_write;
	logic	do_read;

	assign do_write	= we & ~full;			// Full buffer drops the write
	assign do_read	= re & ~empty;

	assign full		= num == NUM_ENTRY;
	assign empty	= num == 0;

	// Pointers wrap at NUM_ENTRY, need not be a power of two
	always_ff @( posedge clock ) begin
		if ( reset ) begin
			wr_ptr	<= '0;
		end
		else if ( do_write ) begin
			wr_ptr	<= ( wr_ptr == WIDTH_PTR'(NUM_ENTRY - 1) ) ? '0 : wr_ptr + 1'b1;
		end
	end

	always_ff @( posedge clock ) begin
		if ( reset ) begin
			rd_ptr	<= '0;
		end
		else if ( do_read ) begin
			rd_ptr	<= ( rd_ptr == WIDTH_PTR'(NUM_ENTRY - 1) ) ? '0 : rd_ptr + 1'b1;
		end
	end

	// Occupancy
	always_ff @( posedge clock ) begin
		if ( reset ) begin
			num		<= '0;
		end
		else if ( do_write & ~do_read ) begin
			num		<= num + 1'b1;
		end
		else if ( do_read & ~do_write ) begin
			num		<= num - 1'b1;
		end
	end

endmodule

// ==== rtl/extern_handle.sv ====
// External port handler
// Command receiver and session control

`timescale 1ns/1ps
`include "tpu_defs.svh"

module extern_handle #(
	parameter int BUFF_SIZE = `BUFF_SIZE
)(
	input  logic				clock,
	input  logic				reset,
	input  tpu_pkg::ext_word_t	ext_in,
	output tpu_pkg::ext_word_t	ext_out,
	output tpu_pkg::mem_req_t	ld_req,
	input  logic				ld_grant,
	input  tpu_pkg::ld_rsp_t	ld_rsp,
	output tpu_pkg::mem_req_t	st_req,
	input  logic				st_grant,
	output tpu_pkg::st_beat_t	st_data,
	input  logic				st_term
);

	import tpu_pkg::*;

	localparam int WIDTH_BUFF = $clog2(BUFF_SIZE);

	serv_state_t				serv_state;
	st_state_t					st_state;
	ld_state_t					ld_state;

	acc_cfg_t					cfg;
	logic						is_load;		// Taken from the stride word

	logic						recv_stride;
	logic						recv_length;
	logic						recv_base;
	logic						session_end;

	// Buffer
	data_t						buff_data [BUFF_SIZE];
	data_t						buff_wdata;
	logic						st_wr;
	logic						ld_wr;
	logic						st_rd;
	logic						ld_rd;
	logic						we;
	logic						re;
	logic	[WIDTH_BUFF-1:0]	wr_ptr;
	logic	[WIDTH_BUFF-1:0]	rd_ptr;
	logic						full;
	logic						empty;

	assign recv_stride	= ext_in.req & ( serv_state == SERV_IDLE );
	assign recv_length	= ext_in.req & ( serv_state == SERV_LENGTH );
	assign recv_base	= ext_in.req & ( serv_state == SERV_BASE );

	assign session_end	= st_term | ( ld_rsp.valid & ld_rsp.term );

	////////////////////////////////////////
	// Buffer routing

	assign st_wr		= ext_in.req & ( st_state != ST_IDLE );
	assign ld_wr		= ld_rsp.valid & ( ld_state == LD_RUN );
	assign st_rd		= ( st_state == ST_RUN ) & ~empty;
	assign ld_rd		= ( ( ld_state == LD_RUN ) | ( ld_state == LD_LAST ) ) & ~empty;

	assign we			= st_wr | ld_wr;
	assign re			= st_rd | ld_rd;
	assign buff_wdata	= ( ld_state != LD_IDLE ) ? ld_rsp.data : ext_in.data;

	always_ff @( posedge clock ) begin
		if ( we & ~full ) begin
			buff_data[ wr_ptr ]	<= buff_wdata;
		end
	end

	////////////////////////////////////////
	// Memory requests and link output

	assign ld_req.req	= ( serv_state == SERV_SET ) & is_load;
	assign ld_req.cfg	= cfg;
	assign st_req.req	= ( serv_state == SERV_SET ) & ~is_load;
	assign st_req.cfg	= cfg;

	assign st_data.valid	= st_rd;
	assign st_data.data		= buff_data[ rd_ptr ];

	assign ext_out.req	= ld_rd;
	assign ext_out.data	= buff_data[ rd_ptr ];
	assign ext_out.rls	= ld_rd & ( ld_state == LD_LAST );

	// Access configuration, low bits of each word
	always_ff @( posedge clock ) begin
		if ( recv_stride ) begin
			cfg.stride	<= ext_in.data[`WIDTH_STRIDE-1:0];
		end
		if ( recv_length ) begin
			cfg.length	<= ext_in.data[`WIDTH_ADDR-1:0];
		end
		if ( recv_base ) begin
			cfg.base	<= ext_in.data[`WIDTH_ADDR-1:0];
		end
	end

	// Service FSM
	always_ff @( posedge clock ) begin
		if ( reset ) begin
			serv_state	<= SERV_IDLE;
			is_load		<= 1'b0;
		end
		else begin
			case ( serv_state )
				SERV_IDLE: begin
					if ( ext_in.req ) begin
						serv_state	<= SERV_LENGTH;
						is_load		<= ext_in.data[`WIDTH_DATA-1];
					end
				end
				SERV_LENGTH: begin
					if ( ext_in.req ) begin
						serv_state	<= SERV_BASE;
					end
				end
				SERV_BASE: begin
					if ( ext_in.req ) begin
						serv_state	<= SERV_SET;
					end
				end
				SERV_SET:	serv_state	<= SERV_RUN;
				SERV_RUN: begin
					if ( session_end ) begin
						serv_state	<= SERV_IDLE;
					end
				end
				default:	serv_state	<= SERV_IDLE;
			endcase
		end
	end

	// Store session, buffering starts right after the base word
	always_ff @( posedge clock ) begin
		if ( reset ) begin
			st_state	<= ST_IDLE;
		end
		else begin
			case ( st_state )
				ST_IDLE:	if ( recv_base & ~is_load )	st_state	<= ST_WAIT;
				ST_WAIT:	if ( st_grant )				st_state	<= ST_RUN;
				ST_RUN:		if ( st_term )				st_state	<= ST_IDLE;
				default:								st_state	<= ST_IDLE;
			endcase
		end
	end

	// Load session
	always_ff @( posedge clock ) begin
		if ( reset ) begin
			ld_state	<= LD_IDLE;
		end
		else begin
			case ( ld_state )
				LD_IDLE:	if ( recv_base & is_load )	ld_state	<= LD_WAIT;
				LD_WAIT:	if ( ld_grant )				ld_state	<= LD_RUN;
				LD_RUN:		if ( ld_wr & ld_rsp.term )	ld_state	<= LD_LAST;
				LD_LAST:								ld_state	<= LD_IDLE;
				default:								ld_state	<= LD_IDLE;
			endcase
		end
	end

	ring_buff_ctrl #(
		.NUM_ENTRY	( BUFF_SIZE	)
	) u_ring_buff_ctrl (
		.clock		( clock		),
		.reset		( reset		),
		.we			( we		),
		.re			( re		),
		.wr_ptr		( wr_ptr	),
		.rd_ptr		( rd_ptr	),
		.full		( full		),
		.empty		( empty		),
		.num		(			)		// Occupancy not needed here
	);

endmodule

// ==== rtl/strided_mem.sv ====
// Strided word memory
// Behavioural on-chip array with fixed grant delay

`timescale 1ns/1ps
`include "tpu_defs.svh"

module strided_mem #(
	parameter int DEPTH = `MEM_DEPTH
)(
	input  logic				clock,
	input  logic				reset,
	input  tpu_pkg::mem_req_t	ld_req,
	output logic				ld_grant,
	output tpu_pkg::ld_rsp_t	ld_rsp,
	input  tpu_pkg::mem_req_t	st_req,
	output logic				st_grant,
	input  tpu_pkg::st_beat_t	st_data,
	output logic				st_term
);

	import tpu_pkg::*;

	localparam int WIDTH_IDX	= $clog2(DEPTH);
	localparam int WIDTH_DELAY	= $clog2(`GRANT_DELAY + 1);

	typedef enum logic [1:0] {
		MEM_IDLE,
		MEM_WAIT,
		MEM_RUN
	} mem_state_t;

	mem_state_t					state;
	logic						is_load;
	acc_cfg_t					cfg;
	logic	[WIDTH_DELAY-1:0]	delay_cnt;
	logic	[WIDTH_IDX-1:0]		idx;			// Current element address
	address_t					count;			// Elements done so far

	data_t						mem [DEPTH];

	logic						grant;
	logic						last;
	logic						ld_valid;
	logic						st_accept;
	logic						step;

	assign grant		= ( state == MEM_WAIT ) & ( delay_cnt == '0 );
	assign ld_grant		= grant & is_load;
	assign st_grant		= grant & ~is_load;

	assign last			= count == cfg.length - 1'b1;
	assign ld_valid		= ( state == MEM_RUN ) & is_load;
	assign st_accept	= ( state == MEM_RUN ) & ~is_load & st_data.valid;
	assign step			= ld_valid | st_accept;

	assign ld_rsp.valid	= ld_valid;
	assign ld_rsp.data	= mem[ idx ];
	assign ld_rsp.term	= ld_valid & last;

	// Control, one session at a time
	always_ff @( posedge clock ) begin
		if ( reset ) begin
			state		<= MEM_IDLE;
			is_load		<= 1'b0;
			delay_cnt	<= '0;
			count		<= '0;
			st_term		<= 1'b0;
		end
		else begin
			st_term		<= st_accept & last;		// Cycle after the final beat
			case ( state )
				MEM_IDLE: begin
					if ( ld_req.req | st_req.req ) begin
						state		<= MEM_WAIT;
						is_load		<= ld_req.req;
						delay_cnt	<= WIDTH_DELAY'(`GRANT_DELAY - 1);
						count		<= '0;
					end
				end
				MEM_WAIT: begin
					if ( grant ) begin
						state		<= MEM_RUN;
					end
					else begin
						delay_cnt	<= delay_cnt - 1'b1;
					end
				end
				MEM_RUN: begin
					if ( step ) begin
						count		<= count + 1'b1;
						if ( last ) begin
							state	<= MEM_IDLE;
						end
					end
				end
				default:	state	<= MEM_IDLE;
			endcase
		end
	end

	// Address walk, wraps modulo DEPTH
	always_ff @( posedge clock ) begin
		if ( ( state == MEM_IDLE ) & ( ld_req.req | st_req.req ) ) begin
			cfg		<= ld_req.req ? ld_req.cfg : st_req.cfg;
			idx		<= ld_req.req ? ld_req.cfg.base[WIDTH_IDX-1:0]
								: st_req.cfg.base[WIDTH_IDX-1:0];
		end
		else if ( step ) begin
			idx		<= idx + cfg.stride[WIDTH_IDX-1:0];
		end
	end

	always_ff @( posedge clock ) begin
		if ( st_accept ) begin
			mem[ idx ]	<= st_data.data;
		end
	end

endmodule

// ==== rtl/extern_port_top.sv ====
// External port subsystem top

`timescale 1ns/1ps
`include "tpu_defs.svh"

module extern_port_top (
	input  logic				clock,
	input  logic				reset,
	input  tpu_pkg::ext_word_t	ext_in,
	output tpu_pkg::ext_word_t	ext_out
);

	import tpu_pkg::*;

	////////////////////////////////////////
	// Handler to memory
	mem_req_t	ld_req;
	mem_req_t	st_req;
	logic		ld_grant;
	logic		st_grant;
	ld_rsp_t	ld_rsp;
	st_beat_t	st_data;
	logic		st_term;

	extern_handle #(
		.BUFF_SIZE	( `BUFF_SIZE	)
	) u_extern_handle (
		.clock		( clock			),
		.reset		( reset			),
		.ext_in		( ext_in		),
		.ext_out	( ext_out		),
		.ld_req		( ld_req		),
		.ld_grant	( ld_grant		),
		.ld_rsp		( ld_rsp		),
		.st_req		( st_req		),
		.st_grant	( st_grant		),
		.st_data	( st_data		),
		.st_term	( st_term		)
	);

	// Stand-in for the memory system
	strided_mem #(
		.DEPTH		( `MEM_DEPTH	)
	) u_strided_mem (
		.clock		( clock			),
		.reset		( reset			),
		.ld_req		( ld_req		),
		.ld_grant	( ld_grant		),
		.ld_rsp		( ld_rsp		),
		.st_req		( st_req		),
		.st_grant	( st_grant		),
		.st_data	( st_data		),
		.st_term	( st_term		)
	);

endmodule

// ==== sim/tb_extern_port.sv ====
// External port testbench

`timescale 1ns/1ps
`include "tpu_defs.svh"

module tb_extern_port;

	import tpu_pkg::*;

	localparam int TIMEOUT = 200;			// Cycles per wait loop

	logic			clock;
	logic			reset;
	ext_word_t		ext_in;
	ext_word_t		ext_out;

	data_t			shadow [`MEM_DEPTH];	// Reference memory
	ext_word_t		exp_q [$];				// Expected link words in order
	ext_word_t		exp_word;
	int				rx_edges [$];			// Edge numbers of received words
	int				cycle = 0;
	int				base_edge;				// Edge at which the base word was taken
	int				err_count = 0;
	int				errs_at_start = 0;
	int				test_count = 0;
	int				fail_tests = 0;

	extern_port_top dut0 (
		.clock		( clock		),
		.reset		( reset		),
		.ext_in		( ext_in	),
		.ext_out	( ext_out	)
	);

	initial begin
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

	always @( posedge clock ) cycle <= cycle + 1;

	////////////////////////////////////////
	// Reference model

	// Element address modulo the memory depth
	function automatic int ref_addr( input address_t base, input stride_t stride, input int i );
		return ( int'(base) + i * int'(stride) ) % `MEM_DEPTH;
	endfunction

	function automatic int rand_gap( input int max_gap );
		return ( max_gap == 0 ) ? 0 : int'($urandom_range(max_gap, 0));
	endfunction

	////////////////////////////////////////
	// Link compare

	always @( posedge clock ) begin
		if ( !reset ) begin
			if ( ext_out.req ) begin
				rx_edges.push_back(cycle);
				assert ( exp_q.size() != 0 ) else begin
					$display("ERR %0t: unexpected link word %h", $time, ext_out.data);
					err_count++;
				end
				if ( exp_q.size() != 0 ) begin
					exp_word = exp_q.pop_front();
					assert ( ext_out.data == exp_word.data ) else begin
						$display("ERR %0t: link data %h, expected %h",
							$time, ext_out.data, exp_word.data);
						err_count++;
					end
					assert ( ext_out.rls == exp_word.rls ) else begin
						$display("ERR %0t: rls %b, expected %b", $time, ext_out.rls, exp_word.rls);
						err_count++;
					end
				end
			end
			else begin
				assert ( !ext_out.rls ) else begin
					$display("ERR %0t: rls high without a word", $time);
					err_count++;
				end
			end
		end
	end

	////////////////////////////////////////
	// Link driving

	task automatic send_word( input data_t data, input int gap );
		repeat ( gap ) begin
			@( posedge clock );
			ext_in	<= '0;
		end
		@( posedge clock );
		ext_in.req	<= 1'b1;
		ext_in.data	<= data;
		ext_in.rls	<= 1'b0;
	endtask

	task automatic release_link();
		@( posedge clock );
		ext_in	<= '0;
	endtask

	task automatic send_command( input logic load, input address_t base, input stride_t stride,
			input address_t length, input int max_gap );
		data_t	stride_word;
		stride_word = data_t'(stride);
		stride_word[`WIDTH_DATA-1] = load;			// Top bit picks load
		send_word(stride_word, rand_gap(max_gap));
		send_word(data_t'(length), rand_gap(max_gap));
		send_word(data_t'(base), rand_gap(max_gap));
		base_edge = cycle + 1;						// DUT takes it on the next edge
	endtask

	task automatic run_store( input address_t base, input stride_t stride,
			input address_t length, input int max_gap );
		data_t	word;
		int		i;
		int		waited;
		send_command(1'b0, base, stride, length, max_gap);
		for ( i = 0; i < int'(length); i++ ) begin
			word = $urandom();
			shadow[ref_addr(base, stride, i)] = word;	// Later writes win
			send_word(word, rand_gap(max_gap));
		end
		release_link();
		waited = 0;
		while ( !dut0.st_term && waited < TIMEOUT ) begin
			@( negedge clock );
			waited++;
		end
		if ( !dut0.st_term ) begin
			$display("Timeout: store at base %0d did not end within %0d cycles", base, TIMEOUT);
			err_count++;
		end
	endtask

	task automatic run_load( input address_t base, input stride_t stride,
			input address_t length, input int max_gap );
		ext_word_t	w;
		int			i;
		int			waited;
		rx_edges.delete();
		for ( i = 0; i < int'(length); i++ ) begin
			w.req	= 1'b1;
			w.data	= shadow[ref_addr(base, stride, i)];
			w.rls	= ( i == int'(length) - 1 );
			exp_q.push_back(w);
		end
		send_command(1'b1, base, stride, length, max_gap);
		release_link();
		waited = 0;
		while ( exp_q.size() != 0 && waited < TIMEOUT ) begin
			@( negedge clock );
			waited++;
		end
		if ( exp_q.size() != 0 ) begin
			$display("Timeout: %0d load words from base %0d never arrived", exp_q.size(), base);
			err_count++;
			exp_q.delete();
		end
	endtask

	task automatic finish_test( input string name );
		test_count++;
		if ( err_count == errs_at_start ) begin
			$display("Test %0d %s: ok", test_count, name);
		end
		else begin
			fail_tests++;
			$display("Test %0d %s: fail, %0d errors", test_count, name, err_count - errs_at_start);
		end
		errs_at_start = err_count;
	endtask

	////////////////////////////////////////
	// Test sequence

	initial begin
		address_t	base3;
		address_t	base6;
		stride_t	stride6;
		int			i;
		void'($urandom(32'h7ef2b64d));
		reset	= 1'b1;
		ext_in	= '0;
		repeat ( 5 ) @( posedge clock );
		reset	<= 1'b0;

		// Link stays quiet after reset
		repeat ( 10 ) begin
			@( negedge clock );
			assert ( !ext_out.req && !ext_out.rls ) else begin
				$display("ERR %0t: link active after reset", $time);
				err_count++;
			end
		end
		finish_test("idle after reset");

		base3 = address_t'($urandom_range(`MEM_DEPTH - 1, 0));
		run_store(base3, stride_t'(1), 16'd1, 0);
		run_load(base3, stride_t'(1), 16'd1, 0);
		finish_test("single word round trip");

		base3 = address_t'($urandom_range(`MEM_DEPTH - 1, 0));
		run_store(base3, stride_t'(3), 16'd8, 3);
		run_load(base3, stride_t'(3), 16'd8, 3);
		finish_test("strided store and load");

		// First walk wraps past the top and the second lands on 0, 6 and 12
		run_store(address_t'(`MEM_DEPTH - 6), stride_t'(3), 16'd6, 2);
		run_store(address_t'(0), stride_t'(6), 16'd3, 2);
		run_load(address_t'(`MEM_DEPTH - 6), stride_t'(3), 16'd7, 1);
		finish_test("address wrap and overlap");

		run_load(base3, stride_t'(3), 16'd8, 2);
		assert ( rx_edges.size() == 8 ) else begin
			$display("ERR %0t: %0d load words seen, expected 8", $time, rx_edges.size());
			err_count++;
		end
		if ( rx_edges.size() != 0 ) begin
			assert ( rx_edges[0] - base_edge == `GRANT_DELAY + 3 ) else begin
				$display("ERR %0t: first word %0d cycles after base, expected %0d",
					$time, rx_edges[0] - base_edge, `GRANT_DELAY + 3);
				err_count++;
			end
		end
		for ( i = 1; i < rx_edges.size(); i++ ) begin
			assert ( rx_edges[i] == rx_edges[i-1] + 1 ) else begin
				$display("ERR %0t: gap before load word %0d", $time, i);
				err_count++;
			end
		end
		finish_test("load timing");

		base6 = address_t'($urandom_range(`MEM_DEPTH - 1, 0));
		stride6 = stride_t'($urandom_range(`MEM_DEPTH - 1, 1));
		run_store(base6, stride6, address_t'(`BUFF_SIZE), 0);
		run_load(base6, stride6, address_t'(`BUFF_SIZE), 0);
		finish_test("full buffer store");

		$display("Tests run %0d, failed %0d, errors %0d", test_count, fail_tests, err_count);
		if ( err_count == 0 ) begin
			$display("*** TEST PASSED ***");
		end
		else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

// ==== build.f ====
+incdir+rtl
rtl/tpu_pkg.sv
rtl/ring_buff_ctrl.sv
rtl/extern_handle.sv
rtl/strided_mem.sv
rtl/extern_port_top.sv
sim/tb_extern_port.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run the external port testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_extern_port -f build.f

out=$(./obj_dir/Vtb_extern_port)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qF '*** TEST PASSED ***'
